//--- src/brPreConsts.svh
// early branch pre-decoder constants
// widths of PC, instruction word, table index and history, plus opcode fields
`ifndef BR_PRE_CONSTS_SVH
`define BR_PRE_CONSTS_SVH

`define BP_PC_BITS 48
`define BP_INSTR_BITS 64
// 64-entry counter table
`define BP_IX_BITS 6
// history xor'ed straight into the index, so same width
`define BP_HIST_BITS 6

// short form, nibble in 15:12 and sub-op in 11:9
`define BP_OP_BRA8_NIB 4'h2
`define BP_OP_BRA8_SUB 3'b000
`define BP_OP_BRACC8_NIB 4'h2
`define BP_OP_BRACC8_SUB 3'b001
// long form, nibble 15:12, sub-op 11:8, selector in 31:29
`define BP_OP_BRA20_NIB 4'hF
`define BP_OP_BRA20_SUB 4'h0
`define BP_OP_BRA20_HI 3'b110
`define BP_OP_BRACC20_NIB 4'hF
`define BP_OP_BRACC20_SUB 4'h0
`define BP_OP_BRACC20_HI 3'b111
// return through link register, whole low halfword
`define BP_OP_RTSU 16'h3012

`endif

//--- src/brPrePkg.sv
// early branch pre-decoder types
// branch kinds, execute resolution code and predictor counter states
package brPrePkg;

	// decoded kind of the word at decode
	typedef enum logic [2:0]
	{
		brNone    = 3'd0,
		brBra8    = 3'd1,
		brBra20   = 3'd2,
		brBraCc8  = 3'd3,
		brBraCc20 = 3'd4,
		brRtsu    = 3'd5
	} brKindT;

	// predication mode of a resolved instruction
	// bit 1 set means conditional
	typedef enum logic [1:0]
	{
		dirUncond   = 2'b00,
		dirNotBra   = 2'b01,
		dirBraTrue  = 2'b10,
		dirBraFalse = 2'b11
	} resModeT;

	// resolution from execute, bit 2 is branch not taken
	typedef struct packed
	{
		logic    notTaken;
		resModeT mode;
	} resDirT;

	// eight-state counters
	// predicts taken when bit 2 differs from bit 1
	typedef enum logic [2:0]
	{
		ctrWeakNt     = 3'b000,
		ctrStrongNt   = 3'b001,
		ctrTrWeakNt   = 3'b010,
		ctrTrStrongNt = 3'b011,
		ctrWeakTk     = 3'b100,
		ctrStrongTk   = 3'b101,
		ctrTrWeakTk   = 3'b110,
		ctrTrStrongTk = 3'b111
	} ctrStateT;

endpackage

//--- src/brPreCfg.sv
// branch predictor configuration
// holds prediction and history enables, written by one strobe,
// and the global history shifted by conditional resolutions
`include "brPreConsts.svh"

module brPreCfg
(
	input  logic                     clock,
	input  logic                     rstN,
	input  logic                     cfgWrite,
	input  logic                     cfgPredEn,
	input  logic                     cfgHistEn,
	input  brPrePkg::resDirT         exBraDir,
	output logic                     predEn,
	output logic [`BP_HIST_BITS-1:0] history
);

	import brPrePkg::*;

	logic   histEn;
	// resolution one cycle behind execute, lines up with the table update
	resDirT exDirQ;

	// both enables captured together on the strobe
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			predEn <= 1'b1;
			histEn <= 1'b1;
		end
		else if (cfgWrite)
		begin
			predEn <= cfgPredEn;
			histEn <= cfgHistEn;
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			exDirQ  <= '{notTaken: 1'b0, mode: dirNotBra};
			history <= '0;
		end
		else
		begin
			exDirQ <= exBraDir;
			// disabled history gives a plain pc-indexed table
			if (!histEn)
				history <= '0;
			else if (exDirQ.mode[1])
				history <= {history[`BP_HIST_BITS-2:0], exDirQ.notTaken};
		end
	end

endmodule

//--- src/brPredTable.sv
// branch prediction counter table
// 64 eight-state counters, read at fetch for decode one cycle later,
// and trained by read-modify-write from the execute resolution stream
`include "brPreConsts.svh"

module brPredTable
(
	input  logic                     clock,
	input  logic                     rstN,
	input  logic [`BP_HIST_BITS-1:0] history,
	input  logic [`BP_PC_BITS-1:0]   ifBraBPc,
	input  logic [`BP_PC_BITS-1:0]   istrBasePc,
	input  logic [`BP_PC_BITS-1:0]   exBraBPc,
	input  brPrePkg::resDirT         exBraDir,
	output logic                     predValid,
	output logic                     predTaken
);

	import brPrePkg::*;

	localparam int Entries = 1 << `BP_IX_BITS;

	ctrStateT ctrs [Entries];

	// fetch side
	logic [`BP_IX_BITS-1:0] ifIx;
	logic [`BP_IX_BITS-1:0] idIx;
	logic [`BP_IX_BITS-1:0] ibIx;
	ctrStateT               ifCnt;

	// execute side, two slots in flight
	logic [`BP_IX_BITS-1:0] exIxA;
	logic [`BP_IX_BITS-1:0] exIx;
	ctrStateT               exCnt;
	ctrStateT               exCntNext;
	resDirT                 exDir;

	// transition table, indexed by {notTaken, state}
	function automatic ctrStateT ctrStep(input ctrStateT cur, input logic notTaken);
		ctrStateT nxt;
		nxt = cur;
		case ({notTaken, cur})
			4'b0000: nxt = ctrStrongNt;
			4'b0001: nxt = ctrStrongNt;
			4'b0010: nxt = ctrWeakNt;
			4'b0011: nxt = ctrTrWeakNt;
			4'b0100: nxt = ctrTrWeakNt;
			4'b0101: nxt = ctrWeakTk;
			4'b0110: nxt = ctrTrStrongNt;
			4'b0111: nxt = ctrTrStrongNt;
			4'b1000: nxt = ctrTrWeakTk;
			4'b1001: nxt = ctrWeakNt;
			4'b1010: nxt = ctrTrStrongTk;
			4'b1011: nxt = ctrTrStrongTk;
			4'b1100: nxt = ctrStrongTk;
			4'b1101: nxt = ctrStrongTk;
			4'b1110: nxt = ctrWeakTk;
			4'b1111: nxt = ctrTrWeakTk;
			default: nxt = cur;
		endcase
		return nxt;
	endfunction

	// gshare style indices
	assign ifIx  = ifBraBPc[`BP_IX_BITS:1] ^ history;
	assign ibIx  = istrBasePc[`BP_IX_BITS:1] ^ history;
	assign exIxA = exBraBPc[`BP_IX_BITS:1] ^ history;

	assign exCntNext = ctrStep(exCnt, exDir.notTaken);

	// decode pc must hit the entry read last cycle
	assign predValid = (ibIx == idIx);
	// xor rule on the counter bits
	assign predTaken = ifCnt[2] ^ ifCnt[1];

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < Entries; i++)
				ctrs[i] <= ctrWeakNt;
			ifCnt <= ctrWeakNt;
			idIx  <= '0;
			exCnt <= ctrWeakNt;
			exIx  <= '0;
			exDir <= '{notTaken: 1'b0, mode: dirNotBra};
		end
		else
		begin
			// fetch read, used by decode next cycle
			ifCnt <= ctrs[ifIx];
			idIx  <= ifIx;
			// execute read slot
			exCnt <= ctrs[exIxA];
			exIx  <= exIxA;
			exDir <= exBraDir;
			// write slot, only conditional resolutions train
			if (exDir.mode[1])
				ctrs[exIx] <= exCntNext;
		end
	end

endmodule

//--- src/brDispDecode.sv
// early branch recognizer and target adder
// classifies the decode word, forms the pc-relative or link target
// and gates conditional branches by the prediction
`include "brPreConsts.svh"

module brDispDecode
(
	input  logic [`BP_INSTR_BITS-1:0] istrWord,
	input  logic [`BP_PC_BITS-1:0]    istrBraPc,
	input  logic [`BP_PC_BITS-1:0]    regValLr,
	input  logic                      predEn,
	input  logic                      predValid,
	input  logic                      predTaken,
	output logic [`BP_PC_BITS-1:0]    preBraPc,
	output logic                      preIsBra
);

	import brPrePkg::*;

	brKindT      kind;
	logic [31:0] disp8;
	logic [31:0] disp20;
	logic [31:0] tgt8;
	logic [31:0] tgt20;
	logic        doCond;

	// low 32 bits of pc plus twice disp
	// 20-bit low add, high part picked from pc-1, pc, pc+1
	function automatic logic [31:0] calcTarget(input logic [31:0] pc, input logic [31:0] disp);
		logic [20:0] lo;
		logic [10:0] hiP0;
		logic [10:0] hiP1;
		logic [10:0] hiN1;
		logic [10:0] hi;
		lo   = {1'b0, pc[20:1]} + disp[19:0];
		hiP0 = pc[31:21];
		hiP1 = pc[31:21] + 11'd1;
		hiN1 = pc[31:21] - 11'd1;
		// negative disp carries all ones into the high part
		if (disp[30])
			hi = lo[20] ? hiP0 : hiN1;
		else
			hi = lo[20] ? hiP1 : hiP0;
		return {hi, lo[19:0], pc[0]};
	endfunction

	// sign from bit 7 in both forms
	assign disp8  = {{24{istrWord[7]}}, istrWord[7:0]};
	assign disp20 = {{12{istrWord[7]}}, istrWord[7:0], istrWord[27:16]};

	assign tgt8  = calcTarget(istrBraPc[31:0], disp8);
	assign tgt20 = calcTarget(istrBraPc[31:0], disp20);

	// classify, rtsu checked first
	always_comb
	begin
		kind = brNone;
		if (istrWord[15:0] == `BP_OP_RTSU)
			kind = brRtsu;
		else if ((istrWord[15:12] == `BP_OP_BRA8_NIB) && (istrWord[11:9] == `BP_OP_BRA8_SUB))
			kind = brBra8;
		else if ((istrWord[15:12] == `BP_OP_BRACC8_NIB) && (istrWord[11:9] == `BP_OP_BRACC8_SUB))
			kind = brBraCc8;
		else if ((istrWord[15:12] == `BP_OP_BRA20_NIB) && (istrWord[11:8] == `BP_OP_BRA20_SUB) &&
			(istrWord[31:29] == `BP_OP_BRA20_HI))
			kind = brBra20;
		else if ((istrWord[15:12] == `BP_OP_BRACC20_NIB) &&
			(istrWord[11:8] == `BP_OP_BRACC20_SUB) && (istrWord[31:29] == `BP_OP_BRACC20_HI))
			kind = brBraCc20;
	end

	// conditional redirect needs enable, entry match and taken counter
	assign doCond = predEn && predValid && predTaken;

	always_comb
	begin
		preBraPc = '0;
		preIsBra = 1'b0;
		case (kind)
			brBra8:
			begin
				preBraPc = {istrBraPc[47:32], tgt8};
				preIsBra = 1'b1;
			end
			brBra20:
			begin
				preBraPc = {istrBraPc[47:32], tgt20};
				preIsBra = 1'b1;
			end
			brBraCc8:
			begin
				preBraPc = doCond ? {istrBraPc[47:32], tgt8} : '0;
				preIsBra = doCond;
			end
			brBraCc20:
			begin
				preBraPc = doCond ? {istrBraPc[47:32], tgt20} : '0;
				preIsBra = doCond;
			end
			brRtsu:
			begin
				preBraPc = regValLr;
				preIsBra = 1'b1;
			end
			default:
			begin
				preBraPc = '0;
				preIsBra = 1'b0;
			end
		endcase
	end

endmodule

//--- src/brPreTop.sv
// early branch pre-decoder top
// joins configuration, counter table and decoder into the redirect output
`include "brPreConsts.svh"

module brPreTop
(
	input  logic                      clock,
	input  logic                      rstN,
	// configuration strobe and levels
	input  logic                      cfgWrite,
	input  logic                      cfgPredEn,
	input  logic                      cfgHistEn,
	// fetch
	input  logic [`BP_PC_BITS-1:0]    ifBraBPc,
	// decode
	input  logic [`BP_INSTR_BITS-1:0] istrWord,
	input  logic [`BP_PC_BITS-1:0]    istrBasePc,
	input  logic [`BP_PC_BITS-1:0]    istrBraPc,
	input  logic [`BP_PC_BITS-1:0]    regValLr,
	// execute resolution
	input  logic [`BP_PC_BITS-1:0]    exBraBPc,
	input  brPrePkg::resDirT          exBraDir,
	// redirect
	output logic [`BP_PC_BITS-1:0]    preBraPc,
	output logic                      preIsBra
);

	logic                     predEn;
	logic [`BP_HIST_BITS-1:0] history;
	logic                     predValid;
	logic                     predTaken;

	brPreCfg brPreCfg_inst
	(
		.clock     (clock),
		.rstN      (rstN),
		.cfgWrite  (cfgWrite),
		.cfgPredEn (cfgPredEn),
		.cfgHistEn (cfgHistEn),
		.exBraDir  (exBraDir),
		.predEn    (predEn),
		.history   (history)
	);

	brPredTable brPredTable_inst
	(
		.clock      (clock),
		.rstN       (rstN),
		.history    (history),
		.ifBraBPc   (ifBraBPc),
		.istrBasePc (istrBasePc),
		.exBraBPc   (exBraBPc),
		.exBraDir   (exBraDir),
		.predValid  (predValid),
		.predTaken  (predTaken)
	);

	// decode path is purely combinational
	brDispDecode brDispDecode_inst
	(
		.istrWord  (istrWord),
		.istrBraPc (istrBraPc),
		.regValLr  (regValLr),
		.predEn    (predEn),
		.predValid (predValid),
		.predTaken (predTaken),
		.preBraPc  (preBraPc),
		.preIsBra  (preIsBra)
	);

endmodule

//--- sim/brPreTb.sv
// early branch pre-decoder testbench
// drives decode, fetch and execute streams, keeps a reference predictor
// and checks the redirect outputs with concurrent assertions
`include "brPreConsts.svh"

module brPreTb;

	timeunit 1ns;
	timeprecision 100ps;

	import brPrePkg::*;

	localparam int Period = 8;
	// cycles per phase for the watchdog limit
	localparam int IdleN = 20;
	localparam int UncondN = 220;
	localparam int RtsuN = 20;
	localparam int CondCycles = 92 * 3;
	localparam int TotalCycles = 5 + IdleN + UncondN + 4 + RtsuN + CondCycles + 20 + 10;

	logic                      clock;
	logic                      rstN;
	logic                      cfgWrite;
	logic                      cfgPredEn;
	logic                      cfgHistEn;
	logic [`BP_PC_BITS-1:0]    ifBraBPc;
	logic [`BP_INSTR_BITS-1:0] istrWord;
	logic [`BP_PC_BITS-1:0]    istrBasePc;
	logic [`BP_PC_BITS-1:0]    istrBraPc;
	logic [`BP_PC_BITS-1:0]    regValLr;
	logic [`BP_PC_BITS-1:0]    exBraBPc;
	resDirT                    exBraDir;
	logic [`BP_PC_BITS-1:0]    preBraPc;
	logic                      preIsBra;

	// reference model state
	ctrStateT                 mCtr [1 << `BP_IX_BITS];
	logic [`BP_HIST_BITS-1:0] mHist;
	ctrStateT                 mIfCnt;
	logic [`BP_IX_BITS-1:0]   mIdIx;
	ctrStateT                 mExCnt;
	logic [`BP_IX_BITS-1:0]   mExIx;
	resDirT                   mExDir;
	logic                     mPredEn;
	logic                     mHistEn;
	brKindT                   expKind;
	logic                     expIsBra;
	logic [`BP_PC_BITS-1:0]   expBraPc;
	logic                     condOk;

	logic [15:0] lfsr = 16'd10;
	int          errCnt = 0;
	int          otherErr = 0;
	int          condHits = 0;

	brPreTop brPreTop_inst
	(
		.clock      (clock),
		.rstN       (rstN),
		.cfgWrite   (cfgWrite),
		.cfgPredEn  (cfgPredEn),
		.cfgHistEn  (cfgHistEn),
		.ifBraBPc   (ifBraBPc),
		.istrWord   (istrWord),
		.istrBasePc (istrBasePc),
		.istrBraPc  (istrBraPc),
		.regValLr   (regValLr),
		.exBraBPc   (exBraBPc),
		.exBraDir   (exBraDir),
		.preBraPc   (preBraPc),
		.preIsBra   (preIsBra)
	);

	always #(Period / 2) clock = ~clock;

	// fibonacci lfsr with taps 16 14 13 11
	// one step per bit
	function automatic logic [47:0] randBits(input int n);
		logic [47:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[46:0], fb};
		end
		return r;
	endfunction

	// kind from the opcode fields
	function automatic brKindT classify(input logic [63:0] w);
		if (w[15:0] == `BP_OP_RTSU)
			return brRtsu;
		if (w[15:12] == `BP_OP_BRA8_NIB && w[11:9] == `BP_OP_BRA8_SUB)
			return brBra8;
		if (w[15:12] == `BP_OP_BRACC8_NIB && w[11:9] == `BP_OP_BRACC8_SUB)
			return brBraCc8;
		if (w[15:12] == `BP_OP_BRA20_NIB && w[11:8] == `BP_OP_BRA20_SUB)
		begin
			if (w[31:29] == `BP_OP_BRA20_HI)
				return brBra20;
			if (w[31:29] == `BP_OP_BRACC20_HI)
				return brBraCc20;
		end
		return brNone;
	endfunction

	// upper 16 bits kept
	// low 32 bits plus twice the displacement
	function automatic logic [47:0] expTarget(input logic [47:0] pc, input logic [63:0] w,
		input logic longForm);
		logic [31:0] d;
		if (longForm)
			d = {{12{w[7]}}, w[7:0], w[27:16]};
		else
			d = {{24{w[7]}}, w[7:0]};
		return {pc[47:32], pc[31:0] + (d << 1)};
	endfunction

	// eight-state transition on the not-taken outcome nt
	function automatic ctrStateT nextState(input ctrStateT cur, input logic nt);
		case (cur)
			ctrWeakNt:     return nt ? ctrTrWeakTk : ctrStrongNt;
			ctrStrongNt:   return nt ? ctrWeakNt : ctrStrongNt;
			ctrTrWeakNt:   return nt ? ctrTrStrongTk : ctrWeakNt;
			ctrTrStrongNt: return nt ? ctrTrStrongTk : ctrTrWeakNt;
			ctrWeakTk:     return nt ? ctrStrongTk : ctrTrWeakNt;
			ctrStrongTk:   return nt ? ctrStrongTk : ctrWeakTk;
			ctrTrWeakTk:   return nt ? ctrWeakTk : ctrTrStrongNt;
			default:       return nt ? ctrTrWeakTk : ctrTrStrongNt;
		endcase
	endfunction

	function automatic logic [63:0] wordShort(input logic cond, input logic [7:0] d);
		logic [47:0] rb;
		logic [2:0]  sub;
		rb = randBits(48);
		sub = cond ? `BP_OP_BRACC8_SUB : `BP_OP_BRA8_SUB;
		return {rb, `BP_OP_BRA8_NIB, sub, rb[0], d};
	endfunction

	function automatic logic [63:0] wordLong(input logic cond, input logic [19:0] d);
		logic [47:0] rb;
		logic [2:0]  hi;
		rb = randBits(48);
		hi = cond ? `BP_OP_BRACC20_HI : `BP_OP_BRA20_HI;
		return {rb[31:0], hi, rb[40], d[11:0], `BP_OP_BRA20_NIB, `BP_OP_BRA20_SUB, d[19:12]};
	endfunction

	// any word outside the branch opcodes
	function automatic logic [63:0] wordOther();
		logic [47:0] rb;
		logic [3:0]  nib;
		rb = randBits(48);
		nib = rb[15:12];
		if (nib == 4'h2 || nib == 4'h3 || nib == 4'hF)
			nib = 4'h5;
		return {rb, nib, rb[11:0]};
	endfunction

	// model mirrors the fetch read and two-slot execute update
	always @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < (1 << `BP_IX_BITS); i++)
				mCtr[i] <= ctrWeakNt;
			mHist <= '0;
			mIfCnt <= ctrWeakNt;
			mIdIx <= '0;
			mExCnt <= ctrWeakNt;
			mExIx <= '0;
			mExDir <= '{notTaken: 1'b0, mode: dirNotBra};
			mPredEn <= 1'b1;
			mHistEn <= 1'b1;
		end
		else
		begin
			if (cfgWrite)
			begin
				mPredEn <= cfgPredEn;
				mHistEn <= cfgHistEn;
			end
			mIfCnt <= mCtr[ifBraBPc[`BP_IX_BITS:1] ^ mHist];
			mIdIx <= ifBraBPc[`BP_IX_BITS:1] ^ mHist;
			mExCnt <= mCtr[exBraBPc[`BP_IX_BITS:1] ^ mHist];
			mExIx <= exBraBPc[`BP_IX_BITS:1] ^ mHist;
			mExDir <= exBraDir;
			if (mExDir.mode[1])
				mCtr[mExIx] <= nextState(mExCnt, mExDir.notTaken);
			if (!mHistEn)
				mHist <= '0;
			else if (mExDir.mode[1])
				mHist <= {mHist[`BP_HIST_BITS-2:0], mExDir.notTaken};
			if (expIsBra && (expKind == brBraCc8 || expKind == brBraCc20))
				condHits++;
		end
	end

	always_comb
	begin
		expKind = classify(istrWord);
		// predicted taken when bit 2 differs from bit 1
		condOk = mPredEn && (mIfCnt[2] ^ mIfCnt[1]) &&
			((istrBasePc[`BP_IX_BITS:1] ^ mHist) == mIdIx);
		expIsBra = 1'b0;
		expBraPc = '0;
		case (expKind)
			brRtsu:
			begin
				expIsBra = 1'b1;
				expBraPc = regValLr;
			end
			brBra8, brBra20:
			begin
				expIsBra = 1'b1;
				expBraPc = expTarget(istrBraPc, istrWord, expKind == brBra20);
			end
			brBraCc8, brBraCc20:
			begin
				expIsBra = condOk;
				expBraPc = condOk ? expTarget(istrBraPc, istrWord, expKind == brBraCc20) : '0;
			end
			default:
			begin
				expIsBra = 1'b0;
			end
		endcase
	end

	checkIsBra: assert property (@(posedge clock) disable iff (!rstN) preIsBra == expIsBra)
	else
	begin
		errCnt++;
		$display("Fail %0t: preIsBra %b, expected %b", $time, $sampled(preIsBra),
			$sampled(expIsBra));
	end

	checkBraPc: assert property (@(posedge clock) disable iff (!rstN) preBraPc == expBraPc)
	else
	begin
		errCnt++;
		$display("Fail %0t: preBraPc %h, expected %h", $time, $sampled(preBraPc),
			$sampled(expBraPc));
	end

	task automatic driveDecode(input logic [63:0] w, input logic [47:0] bra);
		istrWord <= w;
		istrBraPc <= bra;
		istrBasePc <= randBits(48);
		regValLr <= randBits(48);
		ifBraBPc <= randBits(48);
	endtask

	task automatic runIdle(input int n);
		repeat (n)
		begin
			@(posedge clock);
			driveDecode(wordOther(), randBits(48));
		end
	endtask

	task automatic runUncond(input int n);
		logic [47:0] rb;
		repeat (n)
		begin
			rb = randBits(48);
			@(posedge clock);
			if (rb[0])
				driveDecode(wordLong(1'b0, rb[20:1]), randBits(48));
			else
				driveDecode(wordShort(1'b0, rb[8:1]), randBits(48));
		end
	endtask

	// carries across bit 21 in both directions
	task automatic runCarries();
		logic [47:0] pc;
		pc = randBits(48);
		@(posedge clock);
		driveDecode(wordShort(1'b0, 8'h7F), {pc[47:21], 21'h1FFFF0});
		@(posedge clock);
		driveDecode(wordShort(1'b0, 8'h80), {pc[47:21], 21'h000004});
		@(posedge clock);
		driveDecode(wordLong(1'b0, 20'h7F000), {pc[47:21], 21'h1F0000});
		@(posedge clock);
		driveDecode(wordLong(1'b0, 20'h80000), {pc[47:21], 21'h000100});
	endtask

	task automatic runRtsu(input int n);
		logic [47:0] rb;
		repeat (n)
		begin
			rb = randBits(48);
			@(posedge clock);
			// upper fields shaped like a long branch selector
			driveDecode({rb[31:0], `BP_OP_BRA20_HI, rb[44:32], `BP_OP_RTSU}, randBits(48));
		end
	endtask

	// one resolution every third cycle to a fixed pc
	// ntMode selects taken, not taken or random outcomes
	task automatic condPhase(input int rounds, input int ntMode, input logic mismatch);
		logic [47:0] p;
		logic [47:0] rb;
		logic        nt;
		p = randBits(48);
		for (int r = 0; r < rounds; r++)
		begin
			for (int c = 0; c < 3; c++)
			begin
				rb = randBits(48);
				nt = (ntMode == 2) ? rb[30] : (ntMode == 1);
				@(posedge clock);
				istrWord <= rb[0] ? wordLong(1'b1, rb[20:1]) : wordShort(1'b1, rb[8:1]);
				istrBraPc <= randBits(48);
				istrBasePc <= mismatch ? (p ^ 48'h2) : p;
				ifBraBPc <= p;
				exBraBPc <= p;
				if (c == 0)
					exBraDir <= '{notTaken: nt, mode: rb[31] ? dirBraTrue : dirBraFalse};
				else
					exBraDir <= '{notTaken: 1'b0, mode: dirNotBra};
			end
		end
		@(posedge clock);
		exBraDir <= '{notTaken: 1'b0, mode: dirNotBra};
	endtask

	task automatic writeCfg(input logic predEnVal, input logic histEnVal);
		@(posedge clock);
		cfgWrite <= 1'b1;
		cfgPredEn <= predEnVal;
		cfgHistEn <= histEnVal;
		@(posedge clock);
		cfgWrite <= 1'b0;
	endtask

	initial
	begin
		clock = 1'b0;
		rstN = 1'b0;
		cfgWrite = 1'b0;
		cfgPredEn = 1'b1;
		cfgHistEn = 1'b1;
		ifBraBPc = '0;
		istrWord = '0;
		istrBasePc = '0;
		istrBraPc = '0;
		regValLr = '0;
		exBraBPc = '0;
		exBraDir = '{notTaken: 1'b0, mode: dirNotBra};
		repeat (5) @(posedge clock);
		rstN <= 1'b1;
		runIdle(IdleN);
		runUncond(UncondN - 20);
		runCarries();
		runRtsu(RtsuN);
		// fresh entries then training both ways
		condPhase(16, 0, 1'b0);
		condPhase(16, 1, 1'b0);
		// fetch entry trained to predict taken, decode pc on another entry
		condPhase(8, 1, 1'b1);
		condPhase(16, 2, 1'b0);
		// prediction disabled
		writeCfg(1'b0, 1'b1);
		condPhase(12, 1, 1'b0);
		runUncond(20);
		// pc-only indexing
		// random outcomes would move a live history
		writeCfg(1'b1, 1'b0);
		condPhase(16, 2, 1'b0);
		condPhase(8, 0, 1'b0);
		writeCfg(1'b1, 1'b1);
		runIdle(4);
		if (condHits == 0)
		begin
			otherErr++;
			$display("no conditional branch was redirected during the run");
		end
		$display("errors: %0d mismatches, %0d other", errCnt, otherErr);
		if (errCnt == 0 && otherErr == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	// watchdog at twice the expected run length
	initial
	begin
		#(2 * TotalCycles * Period);
		$display("timeout: the run did not finish within %0d cycles", 2 * TotalCycles);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- brPre.f
+incdir+src
src/brPrePkg.sv
src/brPreCfg.sv
src/brPredTable.sv
src/brDispDecode.sv
src/brPreTop.sv
sim/brPreTb.sv

//--- Bender.yml
package:
  name: brPre

sources:
  - include_dirs:
      - src
    files:
      - src/brPrePkg.sv
      - src/brPreCfg.sv
      - src/brPredTable.sv
      - src/brDispDecode.sv
      - src/brPreTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - sim/brPreTb.sv
